/* build.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_regfile.sv
verilog/cpu.sv
dv/cpu_ref_model.sv
dv/cpu_tb.sv

/* dv/cpu_ref_model.sv */
`include "cpu_settings.svh"

package cpu_ref_model;

	// Sources lean toward the last three destinations to stress forwarding
	function automatic logic [`CPU_REG_AW-1:0] pick_src(input logic [`CPU_REG_AW-1:0] recent [$]);
		int unsigned r;
		r = $urandom_range(9);
		if (r < 6 && recent.size() > 0) begin
			return recent[$urandom_range(recent.size() - 1)];
		end
		return (r == 6) ? '0 : $urandom_range(31);
	endfunction

	function automatic void gen_program(ref logic [`CPU_XLEN-1:0] prog [$], input int len);
		logic [`CPU_REG_AW-1:0] recent [$];
		logic [`CPU_REG_AW-1:0] rs;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] rd;
		logic [15:0]            imm;
		int unsigned            kind;
		cpu_pkg::funct_e        fn_list [6] = '{cpu_pkg::fn_and, cpu_pkg::fn_or,
			cpu_pkg::fn_xor, cpu_pkg::fn_nor, cpu_pkg::fn_addu, cpu_pkg::fn_subu};
		cpu_pkg::opcode_e       op_list [5] = '{cpu_pkg::op_andi, cpu_pkg::op_ori,
			cpu_pkg::op_xori, cpu_pkg::op_addiu, cpu_pkg::op_lui};
		// j, beq, addi, slti, lw, sw
		logic [5:0]             bad_op [6] = '{6'h02, 6'h04, 6'h08, 6'h0a, 6'h23, 6'h2b};
		for (int i = 0; i < len; i++) begin
			rs = pick_src(recent);
			rt = pick_src(recent);
			rd = ($urandom_range(15) == 0) ? '0 : $urandom_range(31, 1);
			// Boundary immediates push addiu and lui into wrap-around
			case ($urandom_range(3))
				0:       imm = 16'hffff;
				1:       imm = 16'h8000;
				default: imm = $urandom();
			endcase
			kind = $urandom_range(19);
			if (kind == 0) begin
				prog.push_back('0);
			end else if (kind == 1) begin
				prog.push_back({bad_op[$urandom_range(5)], rs, rt, imm});
			end else if (kind == 2) begin
				// Signed add is outside the subset
				prog.push_back({6'h00, rs, rt, rd, 5'd0, 6'h20});
			end else if (kind < 11) begin
				prog.push_back({cpu_pkg::op_special, rs, rt, rd, 5'd0, fn_list[$urandom_range(5)]});
				recent.push_front(rd);
			end else begin
				prog.push_back({op_list[$urandom_range(4)], rs, rd, imm});
				recent.push_front(rd);
			end
			if (recent.size() > 3) begin
				void'(recent.pop_back());
			end
		end
	endfunction

	// Architectural model, one instruction at a time with no pipeline timing
	function automatic void run_model(
		input logic [`CPU_XLEN-1:0] prog [$],
		ref cpu_pkg::reg_wr_t        exp_q [$],
		ref int                      exp_idx [$]
	);
		logic [`CPU_XLEN-1:0]   regs [`CPU_REG_COUNT];
		logic [`CPU_XLEN-1:0]   w;
		logic [`CPU_XLEN-1:0]   a;
		logic [`CPU_XLEN-1:0]   b;
		logic [`CPU_XLEN-1:0]   res;
		logic [15:0]            imm;
		logic [`CPU_REG_AW-1:0] dest;
		logic                   known;
		foreach (regs[r]) begin
			regs[r] = '0;
		end
		foreach (prog[i]) begin
			w     = prog[i];
			a     = regs[w[25:21]];
			b     = regs[w[20:16]];
			imm   = w[15:0];
			dest  = w[20:16];
			res   = '0;
			known = 1'b1;
			case (w[31:26])
				cpu_pkg::op_special: begin
					dest = w[15:11];
					case (w[5:0])
						cpu_pkg::fn_and:  res = a & b;
						cpu_pkg::fn_or:   res = a | b;
						cpu_pkg::fn_xor:  res = a ^ b;
						cpu_pkg::fn_nor:  res = ~(a | b);
						cpu_pkg::fn_addu: res = a + b;
						cpu_pkg::fn_subu: res = a - b;
						default:          known = 1'b0;
					endcase
				end
				cpu_pkg::op_andi:  res = a & {16'h0000, imm};
				cpu_pkg::op_ori:   res = a | {16'h0000, imm};
				cpu_pkg::op_xori:  res = a ^ {16'h0000, imm};
				cpu_pkg::op_addiu: res = a + {{16{imm[15]}}, imm};
				cpu_pkg::op_lui:   res = {imm, 16'h0000};
				default:           known = 1'b0;
			endcase
			// r0 is never written, so its reads stay zero
			if (known && dest != '0) begin
				regs[dest] = res;
				exp_q.push_back('{we: 1'b1, addr: dest, data: res});
				exp_idx.push_back(i);
			end
		end
	endfunction

endpackage

/* dv/cpu_tb.sv */
`include "cpu_settings.svh"

module cpu_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned SEED        = 32'hd155_5f62;
	localparam int          PROG_LEN    = 200;
	localparam int          DRAIN       = 10;
	localparam int          CYCLE_LIMIT = PROG_LEN + 50;
	localparam int          DRIVE_DLY   = 1;

	logic                   clk = 1'b0;
	logic                   rst_n_i;
	logic [`CPU_XLEN-1:0]   rom_data_i;
	logic                   rom_ce_o;
	logic [`CPU_ROM_AW-1:0] rom_addr_o;
	cpu_pkg::reg_wr_t       commit_o;

	logic [`CPU_XLEN-1:0]   rom [2**`CPU_ROM_AW];
	logic [`CPU_XLEN-1:0]   prog [$];
	cpu_pkg::reg_wr_t       exp_q [$];
	int                     exp_idx [$];
	int                     cyc = 0;
	int                     fetch_cnt = 0;
	int                     release_cyc = -1;
	int                     first_fetch_cyc = -1;

	cpu dut_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_data_i (rom_data_i),
		.rom_ce_o   (rom_ce_o),
		.rom_addr_o (rom_addr_o),
		.commit_o   (commit_o)
	);

	always #2 clk = ~clk;

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic compare_commit(input string name, input cpu_pkg::reg_wr_t exp,
		input cpu_pkg::reg_wr_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected we=%b addr=%0d data=%h actual we=%b addr=%0d data=%h",
				name, exp.we, exp.addr, exp.data, act.we, act.addr, act.data);
			abort_run();
		end
	endtask

	task automatic compare_addr(input string name, input logic [`CPU_ROM_AW-1:0] exp,
		input logic [`CPU_ROM_AW-1:0] act);
		if (exp !== act) begin
			$display("mismatch %s: expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_cycle(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("mismatch %s: expected cycle %0d actual cycle %0d", name, exp, act);
			abort_run();
		end
	endtask

	// External ROM answers the current address shortly after the edge
	always @(posedge clk) begin
		#DRIVE_DLY;
		rom_data_i = rom_ce_o ? rom[rom_addr_o] : '0;
	end

	// Sampled mid-cycle where all DUT outputs are settled
	always @(negedge clk) begin
		cyc++;
		if (cyc > CYCLE_LIMIT) begin
			fail_run($sformatf("timeout after %0d cycles with %0d words fetched", cyc, fetch_cnt));
		end
		if (!rst_n_i) begin
			if (rom_ce_o !== 1'b0 || commit_o.we !== 1'b0) begin
				fail_run("ROM chip enable or commit active while in reset");
			end
		end else begin
			if (release_cyc < 0) begin
				release_cyc = cyc;
			end
			if (rom_ce_o === 1'b1) begin
				if (fetch_cnt == 0) begin
					first_fetch_cyc = cyc;
					compare_cycle("first_fetch", release_cyc + 1, cyc);
				end
				compare_addr($sformatf("fetch_addr[%0d]", fetch_cnt), fetch_cnt[`CPU_ROM_AW-1:0],
					rom_addr_o);
				fetch_cnt++;
			end else if (cyc > release_cyc) begin
				fail_run("ROM chip enable low after the first cycle out of reset");
			end
			if (commit_o.we === 1'b1) begin
				if (exp_q.size() == 0) begin
					fail_run("commit seen with no expected register write left");
				end else begin
					// Fetch to commit is four cycles, in program order
					compare_cycle($sformatf("commit_cycle[%0d]", exp_idx[0]),
						first_fetch_cyc + exp_idx[0] + 4, cyc);
					compare_commit($sformatf("commit[%0d]", exp_idx[0]), exp_q.pop_front(),
						commit_o);
					void'(exp_idx.pop_front());
				end
			end
		end
	end

	initial begin
		rst_n_i    = 1'b0;
		rom_data_i = '0;
		void'($urandom(SEED));
		cpu_ref_model::gen_program(prog, PROG_LEN);
		cpu_ref_model::run_model(prog, exp_q, exp_idx);
		foreach (rom[a]) begin
			rom[a] = (a < PROG_LEN) ? prog[a] : '0;
		end
		repeat (2) @(posedge clk);
		#DRIVE_DLY rst_n_i = 1'b1;
		wait (fetch_cnt >= PROG_LEN);
		repeat (DRAIN) @(posedge clk);
		if (exp_q.size() != 0) begin
			fail_run($sformatf("%0d expected register writes never committed", exp_q.size()));
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

/* verilog/cpu.sv */
`include "cpu_settings.svh"

module cpu (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic [`CPU_XLEN-1:0]    rom_data_i,
	output logic                    rom_ce_o,
	output logic [`CPU_ROM_AW-1:0]  rom_addr_o,
	output cpu_pkg::reg_wr_t        commit_o
);

	cpu_pkg::if_id_t         if_id;
	cpu_pkg::id_ex_t         id_ex;
	cpu_pkg::reg_wr_t        ex_fwd;
	cpu_pkg::reg_wr_t        mem_fwd;
	logic [`CPU_REG_AW-1:0]  rs_addr;
	logic [`CPU_REG_AW-1:0]  rt_addr;
	logic [`CPU_XLEN-1:0]    rs_data;
	logic [`CPU_XLEN-1:0]    rt_data;

	cpu_fetch fetch_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_data_i (rom_data_i),
		.rom_ce_o   (rom_ce_o),
		.rom_addr_o (rom_addr_o),
		.if_id_o    (if_id)
	);

	cpu_decode decode_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.if_id_i    (if_id),
		.rs_addr_o  (rs_addr),
		.rt_addr_o  (rt_addr),
		.rs_data_i  (rs_data),
		.rt_data_i  (rt_data),
		.ex_fwd_i   (ex_fwd),
		.mem_fwd_i  (mem_fwd),
		.id_ex_o    (id_ex)
	);

	// Execute owns the memory and write-back registers too
	cpu_execute execute_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.id_ex_i    (id_ex),
		.ex_fwd_o   (ex_fwd),
		.mem_fwd_o  (mem_fwd),
		.commit_o   (commit_o)
	);

	// Commit doubles as the register file write port
	cpu_regfile regfile_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.wr_i       (commit_o),
		.rs_addr_i  (rs_addr),
		.rt_addr_i  (rt_addr),
		.rs_data_o  (rs_data),
		.rt_data_o  (rt_data)
	);

endmodule

/* verilog/cpu_decode.sv */
`include "cpu_settings.svh"

module cpu_decode (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  cpu_pkg::if_id_t         if_id_i,
	output logic [`CPU_REG_AW-1:0]  rs_addr_o,
	output logic [`CPU_REG_AW-1:0]  rt_addr_o,
	input  logic [`CPU_XLEN-1:0]    rs_data_i,
	input  logic [`CPU_XLEN-1:0]    rt_data_i,
	input  cpu_pkg::reg_wr_t        ex_fwd_i,
	input  cpu_pkg::reg_wr_t        mem_fwd_i,
	output cpu_pkg::id_ex_t         id_ex_o
);

	cpu_pkg::opcode_e        opcode;
	cpu_pkg::funct_e         funct;
	logic [`CPU_REG_AW-1:0]  rs;
	logic [`CPU_REG_AW-1:0]  rt;
	logic [`CPU_REG_AW-1:0]  rd;
	logic [15:0]             imm;

	cpu_pkg::alu_op_e        alu_op;
	logic                    use_imm;
	logic                    valid;
	logic [`CPU_XLEN-1:0]    imm_ext;
	logic [`CPU_REG_AW-1:0]  dest;
	cpu_pkg::id_ex_t         id_ex_d;

	// Instruction fields
	assign opcode = cpu_pkg::opcode_e'(if_id_i.inst[31:26]);
	assign rs     = if_id_i.inst[25:21];
	assign rt     = if_id_i.inst[20:16];
	assign rd     = if_id_i.inst[15:11];
	assign funct  = cpu_pkg::funct_e'(if_id_i.inst[5:0]);
	assign imm    = if_id_i.inst[15:0];

	assign rs_addr_o = rs;
	assign rt_addr_o = rt;

	// Youngest producer wins; the regfile port already covers write-back
	function automatic logic [`CPU_XLEN-1:0] fwd_operand(
		input logic [`CPU_REG_AW-1:0] src,
		input logic [`CPU_XLEN-1:0]   rf_data
	);
		logic [`CPU_XLEN-1:0] val;
		if (src == '0) begin
			val = '0;
		end else if (ex_fwd_i.we && ex_fwd_i.addr == src) begin
			val = ex_fwd_i.data;
		end else if (mem_fwd_i.we && mem_fwd_i.addr == src) begin
			val = mem_fwd_i.data;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	always_comb begin
		alu_op  = cpu_pkg::alu_and;
		use_imm = 1'b0;
		valid   = 1'b1;
		imm_ext = '0;
		dest    = rt;
		case (opcode)
			cpu_pkg::op_special: begin
				dest = rd;
				case (funct)
					cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
					cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
					cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
					cpu_pkg::fn_nor:  alu_op = cpu_pkg::alu_nor;
					cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
					cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
					// Includes the all-zero nop
					default:          valid  = 1'b0;
				endcase
			end
			cpu_pkg::op_andi: begin
				alu_op  = cpu_pkg::alu_and;
				use_imm = 1'b1;
				imm_ext = {{(`CPU_XLEN-16){1'b0}}, imm};
			end
			cpu_pkg::op_ori: begin
				alu_op  = cpu_pkg::alu_or;
				use_imm = 1'b1;
				imm_ext = {{(`CPU_XLEN-16){1'b0}}, imm};
			end
			cpu_pkg::op_xori: begin
				alu_op  = cpu_pkg::alu_xor;
				use_imm = 1'b1;
				imm_ext = {{(`CPU_XLEN-16){1'b0}}, imm};
			end
			cpu_pkg::op_addiu: begin
				alu_op  = cpu_pkg::alu_add;
				use_imm = 1'b1;
				imm_ext = {{(`CPU_XLEN-16){imm[15]}}, imm};
			end
			cpu_pkg::op_lui: begin
				alu_op  = cpu_pkg::alu_lui;
				use_imm = 1'b1;
				imm_ext = {imm, {(`CPU_XLEN-16){1'b0}}};
			end
			default: valid = 1'b0;
		endcase
	end

	always_comb begin
		id_ex_d.alu_op = alu_op;
		id_ex_d.op_a   = fwd_operand(rs, rs_data_i);
		id_ex_d.op_b   = use_imm ? imm_ext : fwd_operand(rt, rt_data_i);
		id_ex_d.we     = valid && (dest != '0);
		id_ex_d.waddr  = dest;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_ex_o <= '0;
		end else begin
			id_ex_o <= id_ex_d;
		end
	end

endmodule

/* verilog/cpu_execute.sv */
`include "cpu_settings.svh"

module cpu_execute (
	input  logic              clk,
	input  logic              rst_n_i,
	input  cpu_pkg::id_ex_t   id_ex_i,
	output cpu_pkg::reg_wr_t  ex_fwd_o,
	output cpu_pkg::reg_wr_t  mem_fwd_o,
	output cpu_pkg::reg_wr_t  commit_o
);

	logic [`CPU_XLEN-1:0]  alu_res;
	cpu_pkg::reg_wr_t      ex_res;
	cpu_pkg::reg_wr_t      mem_q;
	cpu_pkg::reg_wr_t      wb_q;

	// ALU, add and sub wrap naturally at the word width
	always_comb begin
		case (id_ex_i.alu_op)
			cpu_pkg::alu_and: alu_res = id_ex_i.op_a & id_ex_i.op_b;
			cpu_pkg::alu_or:  alu_res = id_ex_i.op_a | id_ex_i.op_b;
			cpu_pkg::alu_xor: alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
			cpu_pkg::alu_nor: alu_res = ~(id_ex_i.op_a | id_ex_i.op_b);
			cpu_pkg::alu_add: alu_res = id_ex_i.op_a + id_ex_i.op_b;
			cpu_pkg::alu_sub: alu_res = id_ex_i.op_a - id_ex_i.op_b;
			// Immediate was already shifted in decode
			cpu_pkg::alu_lui: alu_res = id_ex_i.op_b;
			default:          alu_res = '0;
		endcase
	end

	always_comb begin
		ex_res.we   = id_ex_i.we;
		ex_res.addr = id_ex_i.waddr;
		ex_res.data = alu_res;
	end

	// Memory stage only carries the result, no loads or stores
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_q <= '0;
		end else begin
			mem_q <= ex_res;
		end
	end

	// Write-back register
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_q <= '0;
		end else begin
			wb_q <= mem_q;
		end
	end

	// Forwarding taps toward decode
	assign ex_fwd_o  = ex_res;
	assign mem_fwd_o = mem_q;

	assign commit_o = wb_q;

	// Decode must have squashed any write to r0
	a_no_r0_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
		commit_o.we |-> commit_o.addr != '0)
		else $error("commit targets register zero");

endmodule

/* verilog/cpu_fetch.sv */
`include "cpu_settings.svh"

module cpu_fetch (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic [`CPU_XLEN-1:0]    rom_data_i,
	output logic                    rom_ce_o,
	output logic [`CPU_ROM_AW-1:0]  rom_addr_o,
	output cpu_pkg::if_id_t         if_id_o
);

	logic [`CPU_XLEN-1:0] pc_q;
	logic                 ce_q;

	// Chip enable comes up one cycle after reset, PC runs only while enabled
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ce_q <= 1'b0;
			pc_q <= '0;
		end else begin
			ce_q <= 1'b1;
			if (ce_q) begin
				pc_q <= pc_q + `CPU_PC_STEP;
			end
		end
	end

	assign rom_ce_o   = ce_q;
	assign rom_addr_o = pc_q[`CPU_ROM_AW+1:2];

	// ROM data is only valid with chip enable, otherwise feed a bubble
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			if_id_o <= '0;
		end else if (ce_q) begin
			if_id_o <= '{pc: pc_q, inst: rom_data_i};
		end else begin
			if_id_o <= '0;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		pc_q[1:0] == 2'b00)
		else $error("fetch PC not word aligned: %h", pc_q);

endmodule

/* verilog/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_addiu   = 6'h09,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f
	} opcode_e;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27
	} funct_e;

	// Internal ALU operation
	typedef enum logic [2:0] {
		alu_and = 3'd0,
		alu_or  = 3'd1,
		alu_xor = 3'd2,
		alu_nor = 3'd3,
		alu_add = 3'd4,
		alu_sub = 3'd5,
		alu_lui = 3'd6
	} alu_op_e;

	// One register write, also used by the forwarding taps and trace port
	typedef struct packed {
		logic                     we;
		logic [`CPU_REG_AW-1:0]   addr;
		logic [`CPU_XLEN-1:0]     data;
	} reg_wr_t;

	// Fetch to decode
	typedef struct packed {
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] inst;
	} if_id_t;

	// Decode to execute, operands already resolved
	typedef struct packed {
		alu_op_e                  alu_op;
		logic [`CPU_XLEN-1:0]     op_a;
		logic [`CPU_XLEN-1:0]     op_b;
		logic                     we;
		logic [`CPU_REG_AW-1:0]   waddr;
	} id_ex_t;

endpackage

/* verilog/cpu_regfile.sv */
`include "cpu_settings.svh"

module cpu_regfile (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  cpu_pkg::reg_wr_t        wr_i,
	input  logic [`CPU_REG_AW-1:0]  rs_addr_i,
	input  logic [`CPU_REG_AW-1:0]  rt_addr_i,
	output logic [`CPU_XLEN-1:0]    rs_data_o,
	output logic [`CPU_XLEN-1:0]    rt_data_o
);

	logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

	// Decode squashes r0 writes upstream
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_i.we) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	// R0 reads zero and a same-cycle write bypasses the array
	function automatic logic [`CPU_XLEN-1:0] read_port(
		input logic [`CPU_REG_AW-1:0] addr
	);
		logic [`CPU_XLEN-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (wr_i.we && wr_i.addr == addr) begin
			val = wr_i.data;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		rs_data_o = read_port(rs_addr_i);
		rt_data_o = read_port(rt_addr_i);
	end

	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
		regs[0] == '0)
		else $error("register zero storage was written");

endmodule

/* verilog/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and instruction width
`define CPU_XLEN 32

// Architectural register file size
`define CPU_REG_COUNT 32

// Register index width derived from the count
`define CPU_REG_AW $clog2(`CPU_REG_COUNT)

// Instruction ROM word address width
`define CPU_ROM_AW 10

// PC steps one word per cycle
`define CPU_PC_STEP 4

`endif
